// File: src.f
+incdir+tests
source/rvPkg.sv
source/aluPath.sv
source/branchPath.sv
source/resultMerge.sv
source/execStage.sv
tests/execStageTb.sv

// File: Bender.yml
package:
  name: execStage

sources:
  - files:
      - source/rvPkg.sv
      - source/aluPath.sv
      - source/branchPath.sv
      - source/resultMerge.sv
      - source/execStage.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/execStageTb.sv

// File: tests/execModel.svh
`ifndef EXEC_MODEL_SVH
`define EXEC_MODEL_SVH

typedef struct packed {
    logic   valid;
    logic   write;
    regIdxT rd;
    wordT   value;
    logic   redirect;
    wordT   target;
} expT;

// expected stage outputs for one instruction, straight from the RV32I encoding
function automatic expT expectedResult(input logic valid, input wordT pcIn,
                                       input logic [31:0] ins, input wordT a, input wordT b);
    expT        e;
    wordT       immI, immB, immJ, immU, opB;
    logic [6:0] opc;
    logic [2:0] f3;
    logic       alt;
    e    = '0;
    opc  = ins[6:0];
    f3   = ins[14:12];
    alt  = ins[30];    // SUB / SRA / SRAI select
    immI = {{20{ins[31]}}, ins[31:20]};
    immB = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
    immJ = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
    immU = {ins[31:12], 12'b0};
    e.valid = valid;
    e.rd    = ins[11:7];
    case (opc)
        opcOp, opcOpImm: begin
            opB     = (opc == opcOp) ? b : immI;
            e.write = 1'b1;
            case (f3)
                3'd0:    e.value = (opc == opcOp && alt) ? a - opB : a + opB;
                3'd1:    e.value = a << opB[4:0];
                3'd2:    e.value = {31'b0, $signed(a) < $signed(opB)};
                3'd3:    e.value = {31'b0, a < opB};
                3'd4:    e.value = a ^ opB;
                3'd5: begin
                    if (alt) e.value = $signed(a) >>> opB[4:0];
                    else     e.value = a >> opB[4:0];
                end
                3'd6:    e.value = a | opB;
                default: e.value = a & opB;
            endcase
        end
        opcLui: begin
            e.write = 1'b1;
            e.value = immU;
        end
        opcAuipc: begin
            e.write = 1'b1;
            e.value = pcIn + immU;
        end
        opcJal, opcJalr: begin
            e.write    = 1'b1;
            e.value    = pcIn + 32'd4;
            e.redirect = 1'b1;
            e.target   = (opc == opcJal) ? pcIn + immJ : (a + immI) & 32'hffff_fffe;
        end
        opcBranch: begin
            e.target = pcIn + immB;
            case (f3)
                3'b000:  e.redirect = a == b;
                3'b001:  e.redirect = a != b;
                3'b100:  e.redirect = $signed(a) < $signed(b);
                3'b101:  e.redirect = $signed(a) >= $signed(b);
                3'b110:  e.redirect = a < b;
                3'b111:  e.redirect = a >= b;
                default: e.redirect = 1'b0;
            endcase
        end
        default: ;    // anything else is ignored by the stage
    endcase
    if (!valid || e.rd == 5'd0) e.write = 1'b0;
    if (!valid) e.redirect = 1'b0;
    return e;
endfunction

`endif

// File: tests/execStageTb.sv
`timescale 1ns/100ps

module execStageTb import rvPkg::*; ();

    localparam int numInstr    = 2000;    // issue slots, inValid low in some
    localparam int resetCycles = 10;
    localparam int cycleLimit  = numInstr + resetCycles + 20;

    logic   clk = 1'b0;
    logic   arstN;
    logic   inValid;
    wordT   pc;
    instrU  instr;
    wordT   rs1Value, rs2Value;
    logic   resValid, rdWrite, redirect;
    regIdxT rdIndex;
    wordT   rdValue, redirectPc;

    logic [31:0] lfsrState = 32'd35;
    int          cycleCount = 0;
    int          checkCount = 0;

    `include "execModel.svh"

    expT expQ[$];

    execStage UUT (
        .clk        (clk),
        .arstN      (arstN),
        .inValid    (inValid),
        .pc         (pc),
        .instr      (instr),
        .rs1Value   (rs1Value),
        .rs2Value   (rs2Value),
        .resValid   (resValid),
        .rdWrite    (rdWrite),
        .rdIndex    (rdIndex),
        .rdValue    (rdValue),
        .redirect   (redirect),
        .redirectPc (redirectPc)
    );

    always #4 clk = ~clk;

    task automatic failRun(input string what);
        $display("%s", what);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount > cycleLimit)
            failRun($sformatf("timeout: run did not finish within %0d cycles", cycleLimit));
    end

    // x^32 + x^22 + x^2 + x + 1, one step per bit
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] bits;
        logic        fb;
        int          k;
        bits = '0;
        for (k = 0; k < n; k++) begin
            fb        = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
            lfsrState = {lfsrState[30:0], fb};
            bits      = {bits[30:0], fb};
        end
        return bits;
    endfunction

    task automatic checkWord(input string name, input wordT exp, input wordT act);
        if (act !== exp)
            failRun($sformatf("Error: %s expected %h actual %h", name, exp, act));
    endtask

    task automatic checkRegIdx(input string name, input regIdxT exp, input regIdxT act);
        if (act !== exp)
            failRun($sformatf("Error: %s expected %0d actual %0d", name, exp, act));
    endtask

    task automatic checkFlag(input string name, input logic exp, input logic act);
        if (act !== exp)
            failRun($sformatf("Error: %s expected %b actual %b", name, exp, act));
    endtask

    // legal encodings only, except the one slot for foreign opcodes
    function automatic logic [31:0] makeInstr();
        logic [3:0]  kind;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm12;
        logic [1:0]  sel;
        regIdxT      rd, rs1, rs2;
        kind  = 4'(randBits(4));
        rd    = regIdxT'(randBits(5));
        rs1   = regIdxT'(randBits(5));
        rs2   = regIdxT'(randBits(5));
        f3    = 3'(randBits(3));
        imm12 = 12'(randBits(12));
        if (kind <= 4'd2) begin
            f7 = ((f3 == f3AddSub || f3 == f3SrlSra) && randBits(1) != 0) ? 7'h20 : 7'h00;
            return {f7, rs2, rs1, f3, rd, opcOp};
        end else if (kind <= 4'd5) begin
            if (f3 == f3Sll) imm12[11:5] = 7'h00;
            else if (f3 == f3SrlSra) imm12[11:5] = (randBits(1) != 0) ? 7'h20 : 7'h00;
            return {imm12, rs1, f3, rd, opcOpImm};
        end else if (kind == 4'd6) begin
            return {20'(randBits(20)), rd, opcLui};
        end else if (kind == 4'd7) begin
            return {20'(randBits(20)), rd, opcAuipc};
        end else if (kind == 4'd8) begin
            return {20'(randBits(20)), rd, opcJal};
        end else if (kind == 4'd9) begin
            return {imm12, rs1, 3'b000, rd, opcJalr};
        end else if (kind <= 4'd14) begin
            if (!f3[2]) f3[1] = 1'b0;    // skip 010 and 011
            return {imm12[11:5], rs2, rs1, f3, imm12[4:0], opcBranch};
        end
        sel = 2'(randBits(2));
        case (sel)
            2'd0:    return {25'(randBits(25)), 7'b0000011};    // load
            2'd1:    return {25'(randBits(25)), 7'b0100011};    // store
            2'd2:    return {25'(randBits(25)), 7'b0001111};
            default: return {25'(randBits(25)), 7'b1110011};    // system
        endcase
    endfunction

    task automatic checkOutputs(input expT e);
        string tag;
        tag        = $sformatf("result %0d", checkCount);
        checkCount = checkCount + 1;
        checkFlag({tag, " resValid"}, e.valid, resValid);
        checkFlag({tag, " rdWrite"}, e.write, rdWrite);
        checkFlag({tag, " redirect"}, e.redirect, redirect);
        if (e.write) begin
            checkRegIdx({tag, " rdIndex"}, e.rd, rdIndex);
            checkWord({tag, " rdValue"}, e.value, rdValue);
        end
        if (e.redirect) checkWord({tag, " redirectPc"}, e.target, redirectPc);
    endtask

    initial begin
        int slot;
        arstN    = 1'b0;
        inValid  = 1'b0;
        pc       = '0;
        instr    = '0;
        rs1Value = '0;
        rs2Value = '0;
        repeat (resetCycles) begin
            @(negedge clk);
            checkFlag("reset resValid", 1'b0, resValid);
            checkFlag("reset rdWrite", 1'b0, rdWrite);
            checkFlag("reset redirect", 1'b0, redirect);
        end
        arstN = 1'b1;
        // the idle cycles still in flight when reset lets go
        repeat (2) expQ.push_back(expectedResult(1'b0, '0, '0, '0, '0));
        for (slot = 0; slot < numInstr; slot++) begin
            if (expQ.size() == 2) checkOutputs(expQ.pop_front());
            inValid  = randBits(3) != 0;
            pc       = {30'(randBits(30)), 2'b00};
            instr    = makeInstr();
            rs1Value = randBits(32);
            rs2Value = (randBits(2) == 0) ? rs1Value : randBits(32);    // equal now and then
            expQ.push_back(expectedResult(inValid, pc, instr, rs1Value, rs2Value));
            @(negedge clk);
        end
        while (expQ.size() > 0) begin
            checkOutputs(expQ.pop_front());
            inValid = 1'b0;
            @(negedge clk);
        end
        $display("RESULT: PASS");
        $finish;
    end

endmodule

// File: source/execStage.sv
`timescale 1ns/100ps

module execStage import rvPkg::*; (
    input  logic   clk,
    input  logic   arstN,
    input  logic   inValid,
    input  wordT   pc,
    input  instrU  instr,
    input  wordT   rs1Value,
    input  wordT   rs2Value,
    output logic   resValid,
    output logic   rdWrite,
    output regIdxT rdIndex,
    output wordT   rdValue,
    output logic   redirect,
    output wordT   redirectPc
);

    logic   aluValid, aluWrite;
    wordT   aluResult;
    regIdxT aluRd;

    logic   brValid, brTaken, brLinkWrite;
    wordT   brTarget, brLink;

    aluPath aluPathInst (
        .clk       (clk),
        .arstN     (arstN),
        .inValid   (inValid),
        .pc        (pc),
        .instr     (instr),
        .rs1Value  (rs1Value),
        .rs2Value  (rs2Value),
        .aluValid  (aluValid),
        .aluResult (aluResult),
        .aluWrite  (aluWrite),
        .aluRd     (aluRd)
    );

    branchPath branchPathInst (
        .clk         (clk),
        .arstN       (arstN),
        .inValid     (inValid),
        .pc          (pc),
        .instr       (instr),
        .rs1Value    (rs1Value),
        .rs2Value    (rs2Value),
        .brValid     (brValid),
        .brTaken     (brTaken),
        .brTarget    (brTarget),
        .brLink      (brLink),
        .brLinkWrite (brLinkWrite)
    );

    resultMerge resultMergeInst (
        .clk         (clk),
        .arstN       (arstN),
        .aluValid    (aluValid),
        .aluResult   (aluResult),
        .aluWrite    (aluWrite),
        .aluRd       (aluRd),
        .brValid     (brValid),
        .brTaken     (brTaken),
        .brTarget    (brTarget),
        .brLink      (brLink),
        .brLinkWrite (brLinkWrite),
        .resValid    (resValid),
        .rdWrite     (rdWrite),
        .rdIndex     (rdIndex),
        .rdValue     (rdValue),
        .redirect    (redirect),
        .redirectPc  (redirectPc)
    );

endmodule

// File: source/resultMerge.sv
`timescale 1ns/100ps

module resultMerge import rvPkg::*; (
    input  logic   clk,
    input  logic   arstN,
    input  logic   aluValid,
    input  wordT   aluResult,
    input  logic   aluWrite,
    input  regIdxT aluRd,
    input  logic   brValid,
    input  logic   brTaken,
    input  wordT   brTarget,
    input  wordT   brLink,
    input  logic   brLinkWrite,
    output logic   resValid,
    output logic   rdWrite,
    output regIdxT rdIndex,
    output wordT   rdValue,
    output logic   redirect,
    output wordT   redirectPc
);

    wordT valueNext;
    logic writeNext;
    logic redirectNext;

    // jumps write the link, everything else the ALU side
    assign valueNext = brLinkWrite ? brLink : aluResult;

    // x0 is hardwired, never report a write to it
    assign writeNext = aluValid && (aluWrite || brLinkWrite) && (aluRd != '0);

    assign redirectNext = brValid && brTaken;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            resValid <= 1'b0;
            rdWrite  <= 1'b0;
            redirect <= 1'b0;
        end else begin
            resValid <= aluValid;
            rdWrite  <= writeNext;
            redirect <= redirectNext;
        end
    end

    always_ff @(posedge clk) begin
        rdIndex    <= aluRd;
        rdValue    <= valueNext;
        redirectPc <= brTarget;
    end

    // both paths see the same instruction stream with equal latency
    pathsInStep: assert property (@(posedge clk) disable iff (!arstN)
        aluValid == brValid)
        else $error("ALU and branch paths out of step");

    alignedRedirect: assert property (@(posedge clk) disable iff (!arstN)
        redirect |-> !redirectPc[0])
        else $error("redirect to an odd address");

endmodule

// File: source/branchPath.sv
`timescale 1ns/100ps

module branchPath import rvPkg::*; (
    input  logic  clk,
    input  logic  arstN,
    input  logic  inValid,
    input  wordT  pc,
    input  instrU instr,
    input  wordT  rs1Value,
    input  wordT  rs2Value,
    output logic  brValid,
    output logic  brTaken,
    output wordT  brTarget,
    output wordT  brLink,
    output logic  brLinkWrite
);

    branchOpT brOp;
    wordT     bImm, jImm, iImm;
    wordT     targetNext;
    logic     isEq, isLt, isLtu;
    logic     takenNext;

    always_comb begin
        brOp = brNone;
        case (instr.b.opcode)
            opcBranch: begin
                case (instr.b.funct3)
                    f3Beq:   brOp = brBeq;
                    f3Bne:   brOp = brBne;
                    f3Blt:   brOp = brBlt;
                    f3Bge:   brOp = brBge;
                    f3Bltu:  brOp = brBltu;
                    f3Bgeu:  brOp = brBgeu;
                    default: brOp = brNone;    // 010 and 011 are not branches
                endcase
            end
            opcJal:  brOp = brJal;
            opcJalr: brOp = brJalr;
            default: brOp = brNone;
        endcase
    end

    assign bImm = {{20{instr.b.imm12}}, instr.b.imm11, instr.b.imm10to5,
                   instr.b.imm4to1, 1'b0};
    assign jImm = {{12{instr.j.imm20}}, instr.j.imm19to12, instr.j.imm11,
                   instr.j.imm10to1, 1'b0};
    assign iImm = {{20{instr.i.imm[11]}}, instr.i.imm};

    assign isEq  = rs1Value == rs2Value;
    assign isLt  = $signed(rs1Value) < $signed(rs2Value);
    assign isLtu = rs1Value < rs2Value;

    always_comb begin
        case (brOp)
            brBeq:   takenNext = isEq;
            brBne:   takenNext = !isEq;
            brBlt:   takenNext = isLt;
            brBge:   takenNext = !isLt;
            brBltu:  takenNext = isLtu;
            brBgeu:  takenNext = !isLtu;
            brJal,
            brJalr:  takenNext = 1'b1;
            default: takenNext = 1'b0;
        endcase
    end

    always_comb begin
        if (brOp == brJalr) begin
            targetNext = (rs1Value + iImm) & ~wordT'(1);
        end else if (brOp == brJal) begin
            targetNext = pc + jImm;
        end else begin
            targetNext = pc + bImm;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            brValid     <= 1'b0;
            brTaken     <= 1'b0;
            brLinkWrite <= 1'b0;
        end else begin
            brValid     <= inValid;
            brTaken     <= inValid && takenNext;
            brLinkWrite <= inValid && (brOp == brJal || brOp == brJalr);
        end
    end

    always_ff @(posedge clk) begin
        brTarget <= targetNext;
        brLink   <= pc + 32'd4;
    end

    // pc-relative targets and links assume word-aligned instructions
    alignedPc: assert property (@(posedge clk) disable iff (!arstN)
        inValid && brOp != brNone |-> pc[1:0] == 2'b00)
        else $error("branch or jump at a misaligned pc");

endmodule

// File: source/aluPath.sv
`timescale 1ns/100ps

module aluPath import rvPkg::*; (
    input  logic   clk,
    input  logic   arstN,
    input  logic   inValid,
    input  wordT   pc,
    input  instrU  instr,
    input  wordT   rs1Value,
    input  wordT   rs2Value,
    output logic   aluValid,
    output wordT   aluResult,
    output logic   aluWrite,
    output regIdxT aluRd
);

    logic  isOp, isOpImm, isLui, isAuipc;
    logic  isShift;
    aluOpT aluOp;
    wordT  iImm, uImm;
    wordT  opB;
    wordT  aluOut;
    wordT  resultNext;

    assign isOp    = instr.r.opcode == opcOp;
    assign isOpImm = instr.r.opcode == opcOpImm;
    assign isLui   = instr.u.opcode == opcLui;
    assign isAuipc = instr.u.opcode == opcAuipc;

    assign isShift = (instr.r.funct3 == f3Sll) || (instr.r.funct3 == f3SrlSra);

    assign iImm = {{20{instr.i.imm[11]}}, instr.i.imm};
    assign uImm = {instr.u.imm31to12, 12'b0};

    // bit 30 picks SUB/SRA, for OP-IMM only SRAI looks at it
    always_comb begin
        aluOp = aluAdd;
        case (instr.r.funct3)
            f3AddSub: aluOp = (isOp && instr.r.funct7[5]) ? aluSub : aluAdd;
            f3Sll:    aluOp = aluSll;
            f3Slt:    aluOp = aluSlt;
            f3Sltu:   aluOp = aluSltu;
            f3Xor:    aluOp = aluXor;
            f3SrlSra: aluOp = instr.r.funct7[5] ? aluSra : aluSrl;
            f3Or:     aluOp = aluOr;
            f3And:    aluOp = aluAnd;
            default:  aluOp = aluAdd;
        endcase
    end

    always_comb begin
        if (isOp) begin
            opB = rs2Value;
        end else if (isShift) begin
            opB = wordT'(instr.i.imm[4:0]);    // shamt
        end else begin
            opB = iImm;
        end
    end

    always_comb begin
        case (aluOp)
            aluAdd:  aluOut = rs1Value + opB;
            aluSub:  aluOut = rs1Value - opB;
            aluSll:  aluOut = rs1Value << opB[4:0];
            aluSlt:  aluOut = wordT'($signed(rs1Value) < $signed(opB));
            aluSltu: aluOut = wordT'(rs1Value < opB);
            aluXor:  aluOut = rs1Value ^ opB;
            aluSrl:  aluOut = rs1Value >> opB[4:0];
            aluSra:  aluOut = wordT'($signed(rs1Value) >>> opB[4:0]);
            aluOr:   aluOut = rs1Value | opB;
            aluAnd:  aluOut = rs1Value & opB;
            default: aluOut = '0;
        endcase
    end

    always_comb begin
        if (isLui) begin
            resultNext = uImm;
        end else if (isAuipc) begin
            resultNext = pc + uImm;
        end else begin
            resultNext = aluOut;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            aluValid <= 1'b0;
            aluWrite <= 1'b0;
        end else begin
            aluValid <= inValid;
            aluWrite <= inValid && (isOp || isOpImm || isLui || isAuipc);
        end
    end

    always_ff @(posedge clk) begin
        aluResult <= resultNext;
        aluRd     <= instr.r.rd;
    end

    // only the RV32I funct7 patterns name one of the ten ALU functions
    knownAluOp: assert property (@(posedge clk) disable iff (!arstN)
        inValid && (isOp || (isOpImm && isShift)) |->
            instr.r.funct7 == 7'h00 ||
            (instr.r.funct7 == 7'h20 && (instr.r.funct3 == f3SrlSra ||
                                         (isOp && instr.r.funct3 == f3AddSub))))
        else $error("integer op encoding matches no ALU function");

endmodule

// File: source/rvPkg.sv
package rvPkg;

    localparam int xlen = 32;

    typedef logic [xlen-1:0] wordT;
    typedef logic [4:0]      regIdxT;

    // major opcodes handled by the execute stage
    typedef enum logic [6:0] {
        opcOp     = 7'b0110011,
        opcOpImm  = 7'b0010011,
        opcLui    = 7'b0110111,
        opcAuipc  = 7'b0010111,
        opcJal    = 7'b1101111,
        opcJalr   = 7'b1100111,
        opcBranch = 7'b1100011
    } opcodeT;

    // funct3 of the integer ops, shared by OP and OP-IMM
    localparam logic [2:0] f3AddSub = 3'b000;
    localparam logic [2:0] f3Sll    = 3'b001;
    localparam logic [2:0] f3Slt    = 3'b010;
    localparam logic [2:0] f3Sltu   = 3'b011;
    localparam logic [2:0] f3Xor    = 3'b100;
    localparam logic [2:0] f3SrlSra = 3'b101;
    localparam logic [2:0] f3Or     = 3'b110;
    localparam logic [2:0] f3And    = 3'b111;

    // funct3 of the conditional branches
    localparam logic [2:0] f3Beq  = 3'b000;
    localparam logic [2:0] f3Bne  = 3'b001;
    localparam logic [2:0] f3Blt  = 3'b100;
    localparam logic [2:0] f3Bge  = 3'b101;
    localparam logic [2:0] f3Bltu = 3'b110;
    localparam logic [2:0] f3Bgeu = 3'b111;

    typedef enum logic [3:0] {
        aluAdd, aluSub, aluSll, aluSlt, aluSltu,
        aluXor, aluSrl, aluSra, aluOr, aluAnd
    } aluOpT;

    // nine kinds, so four bits
    typedef enum logic [3:0] {
        brNone, brBeq, brBne, brBlt, brBge, brBltu, brBgeu, brJal, brJalr
    } branchOpT;

    typedef struct packed {
        logic [6:0] funct7;
        regIdxT     rs2;
        regIdxT     rs1;
        logic [2:0] funct3;
        regIdxT     rd;
        opcodeT     opcode;
    } rTypeT;

    typedef struct packed {
        logic [11:0] imm;
        regIdxT      rs1;
        logic [2:0]  funct3;
        regIdxT      rd;
        opcodeT      opcode;
    } iTypeT;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10to5;
        regIdxT     rs2;
        regIdxT     rs1;
        logic [2:0] funct3;
        logic [3:0] imm4to1;
        logic       imm11;
        opcodeT     opcode;
    } bTypeT;

    typedef struct packed {
        logic [19:0] imm31to12;
        regIdxT      rd;
        opcodeT      opcode;
    } uTypeT;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10to1;
        logic       imm11;
        logic [7:0] imm19to12;
        regIdxT     rd;
        opcodeT     opcode;
    } jTypeT;

    typedef union packed {
        rTypeT r;
        iTypeT i;
        bTypeT b;
        uTypeT u;
        jTypeT j;
    } instrU;

endpackage
